// File: ofdm_sync.f
src/sync_pkg.sv
src/flag_detector.sv
src/delay_line.sv
src/peak_tree.sv
src/peak_tracker.sv
src/frame_ctrl.sv
src/data_gate.sv
src/ofdm_sync.sv
tests/tb_clock.sv
tests/ofdm_sync_assert.sv
tests/ofdm_sync_tb.sv

// File: run.sh
#!/bin/sh
# build and run the frame synchronizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
    --top-module ofdm_sync_tb -f ofdm_sync.f

# simulation output goes to the terminal, pass only on the pass line
./obj_dir/Vofdm_sync_tb | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null

// File: src/data_gate.sv
module data_gate (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  sync_pkg::tagged_t           tagged_i,
    input  sync_pkg::bounds_t           bounds_i,
    output sync_pkg::lanes_t            data_o,
    output logic [sync_pkg::PHASES-1:0] valid_o
);

    logic [sync_pkg::PHASES-1:0] hit;

    genvar k;
    for (k = 0; k < sync_pkg::PHASES; k++) begin : g_lane
        logic [sync_pkg::ADDR_W-1:0] addr;

        // address of lane k within the frame
        assign addr = sync_pkg::ADDR_W'(tagged_i.fcyc) * sync_pkg::ADDR_W'(sync_pkg::PHASES)
                    + sync_pkg::ADDR_W'(k);

        // inclusive on both ends
        assign hit[k] = tagged_i.in_frame && bounds_i.valid
                     && (addr >= bounds_i.data_start)
                     && (addr <= bounds_i.data_end);
    end

    // registered valid mask
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= '0;
        end else begin
            valid_o <= hit;
        end
    end

    // samples pass untouched, lanes stay in place
    always_ff @(posedge clk_i) begin
        data_o <= tagged_i.samples;
    end

endmodule

// File: src/delay_line.sv
module delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t stage_q [DEPTH];

    always_ff @(posedge clk_i) begin
        // plain shift of the whole payload
        stage_q[0] <= d_i;
        for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
        // flag bit lives at bit 0, only that bit is flushed
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i][0] <= 1'b0;
            end
        end
    end

    assign q_o = stage_q[DEPTH-1];

endmodule

// File: src/flag_detector.sv
module flag_detector (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [sync_pkg::PHASES-1:0] flags_i,
    output logic                        det_o
);

    // one all-ones test per detection window
    logic [sync_pkg::PHASES/sync_pkg::PD_WINDOW-1:0] win_hit;

    genvar w;
    for (w = 0; w < sync_pkg::PHASES / sync_pkg::PD_WINDOW; w++) begin : g_win
        // a single dropped flag kills the whole window
        assign win_hit[w] = &flags_i[w*sync_pkg::PD_WINDOW +: sync_pkg::PD_WINDOW];
    end

    // strobe for every qualifying input cycle
    // busy filtering is left to frame_ctrl
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            det_o <= 1'b0;
        end else begin
            det_o <= |win_hit;
        end
    end

endmodule

// File: src/frame_ctrl.sv
module frame_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        det_i,
    input  sync_pkg::peak_t             best_i,
    input  logic                        seen_i,
    output logic [sync_pkg::FCYC_W-1:0] fcyc_o,
    output logic                        in_frame_o,
    output sync_pkg::bounds_t           bounds_o
);

    typedef enum logic [1:0] {
        IDLE,
        SEARCH,
        ADDRESS,
        EXTRACT
    } state_t;

    state_t                      state_q;
    logic [sync_pkg::FCYC_W-1:0] cnt_q;
    logic [sync_pkg::ADDR_W-1:0] start_q;
    logic [sync_pkg::ADDR_W-1:0] end_q;
    logic                        valid_q;
    logic [sync_pkg::ADDR_W-1:0] peak_addr;
    logic [sync_pkg::ADDR_W-1:0] last_cyc;

    // sample address of the timing peak
    assign peak_addr = sync_pkg::ADDR_W'(best_i.stamp) * sync_pkg::ADDR_W'(sync_pkg::PHASES)
                     + sync_pkg::ADDR_W'(best_i.lane);

    // last data cycle plus the trip through delay line and output register
    assign last_cyc = end_q / sync_pkg::ADDR_W'(sync_pkg::PHASES)
                    + sync_pkg::ADDR_W'(sync_pkg::DATA_DELAY + 1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    // strobe cycle carries frame cycle 1, counter follows the bus
                    if (det_i) begin
                        state_q <= SEARCH;
                        cnt_q   <= sync_pkg::FCYC_W'(2);
                    end
                end
                SEARCH: begin
                    cnt_q <= cnt_q + 1'b1;
                    // last in-window stamp has cleared tree and tracker
                    if (cnt_q == sync_pkg::FCYC_W'(sync_pkg::SEARCH_LAST
                                                   + sync_pkg::TREE_LAT + 1)) begin
                        state_q <= ADDRESS;
                    end
                end
                ADDRESS: begin
                    cnt_q   <= cnt_q + 1'b1;
                    // no candidate means no data region
                    valid_q <= seen_i;
                    state_q <= EXTRACT;
                end
                default: begin
                    cnt_q <= cnt_q + 1'b1;
                    // data region fully out, drop bounds and rearm
                    if (sync_pkg::ADDR_W'(cnt_q) >= last_cyc) begin
                        state_q <= IDLE;
                        cnt_q   <= '0;
                        valid_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    // boundary values, only meaningful while valid_q is set
    always_ff @(posedge clk_i) begin
        if (state_q == ADDRESS) begin
            start_q <= peak_addr + 1'b1;
            end_q   <= peak_addr + sync_pkg::ADDR_W'(sync_pkg::DATA_SAMPLES);
        end
    end

    // strobes while busy never reach the counter
    assign fcyc_o     = cnt_q;
    assign in_frame_o = (state_q != IDLE);
    assign bounds_o   = '{data_start: start_q, data_end: end_q, valid: valid_q};

endmodule

// File: src/ofdm_sync.sv
module ofdm_sync (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  sync_pkg::lanes_t            samples_i,
    input  logic [sync_pkg::PHASES-1:0] flags_i,
    input  sync_pkg::corr_t             corr_i,
    output sync_pkg::lanes_t            data_o,
    output logic [sync_pkg::PHASES-1:0] valid_o
);

    logic                        det;
    logic [sync_pkg::FCYC_W-1:0] fcyc;
    logic                        in_frame;
    sync_pkg::peak_t             peak;
    sync_pkg::peak_t             best;
    logic                        seen;
    sync_pkg::bounds_t           bounds;
    sync_pkg::tagged_t           tagged_in;
    sync_pkg::tagged_t           tagged_dly;

    // samples tagged with the frame cycle they belong to
    assign tagged_in = '{samples: samples_i, fcyc: fcyc, in_frame: in_frame};

    flag_detector u_flag_detector (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .flags_i(flags_i),
        .det_o  (det)
    );

    // correlation stamped with the current frame cycle
    peak_tree u_peak_tree (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .corr_i(corr_i),
        .fcyc_i(fcyc),
        .peak_o(peak)
    );

    peak_tracker u_peak_tracker (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .det_i (det),
        .peak_i(peak),
        .best_o(best),
        .seen_o(seen)
    );

    frame_ctrl u_frame_ctrl (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .det_i     (det),
        .best_i    (best),
        .seen_i    (seen),
        .fcyc_o    (fcyc),
        .in_frame_o(in_frame),
        .bounds_o  (bounds)
    );

    // holds samples until the bounds are known
    delay_line #(
        .payload_t(sync_pkg::tagged_t),
        .DEPTH    (sync_pkg::DATA_DELAY)
    ) u_data_dly (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .d_i  (tagged_in),
        .q_o  (tagged_dly)
    );

    data_gate u_data_gate (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .tagged_i(tagged_dly),
        .bounds_i(bounds),
        .data_o  (data_o),
        .valid_o (valid_o)
    );

endmodule

// File: src/peak_tracker.sv
module peak_tracker (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            det_i,
    input  sync_pkg::peak_t peak_i,
    output sync_pkg::peak_t best_o,
    output logic            seen_o
);

    sync_pkg::peak_t best_q;
    logic            seen_q;
    logic            in_win;
    logic            take;

    // only stamps inside the search window are candidates
    assign in_win = (peak_i.stamp >= sync_pkg::FCYC_W'(sync_pkg::SEARCH_FIRST))
                 && (peak_i.stamp <= sync_pkg::FCYC_W'(sync_pkg::SEARCH_LAST));

    // first candidate always taken
    // later ones need a strictly larger value, earlier stamp wins a tie
    assign take = in_win && (!seen_q || (peak_i.value > best_q.value));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            seen_q <= 1'b0;
        end else if (det_i) begin
            seen_q <= 1'b0;
        end else if (take) begin
            seen_q <= 1'b1;
        end
    end

    // running best peak, restarts on every detection
    always_ff @(posedge clk_i) begin
        if (det_i) begin
            best_q <= '0;
        end else if (take) begin
            best_q <= peak_i;
        end
    end

    assign best_o = best_q;
    assign seen_o = seen_q;

endmodule

// File: src/peak_tree.sv
module peak_tree (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  sync_pkg::corr_t             corr_i,
    input  logic [sync_pkg::FCYC_W-1:0] fcyc_i,
    output sync_pkg::peak_t             peak_o
);

    // stamp rides beside the tree, same latency
    logic [sync_pkg::FCYC_W-1:0] stamp_dly;

    delay_line #(
        .payload_t(logic [sync_pkg::FCYC_W-1:0]),
        .DEPTH    (sync_pkg::TREE_LAT)
    ) u_stamp_dly (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .d_i  (fcyc_i),
        .q_o  (stamp_dly)
    );

    // layer l halves the candidates, one register per layer
    genvar l, n;
    for (l = 0; l < sync_pkg::TREE_LAT; l++) begin : g_lvl
        for (n = 0; n < (sync_pkg::PHASES >> (l + 1)); n++) begin : g_node
            // a = lower lanes, b = upper lanes
            logic [sync_pkg::CORR_W-1:0] val_a;
            logic [sync_pkg::CORR_W-1:0] val_b;
            logic [sync_pkg::LANE_W-1:0] lane_a;
            logic [sync_pkg::LANE_W-1:0] lane_b;
            logic [sync_pkg::CORR_W-1:0] val_q;
            logic [sync_pkg::LANE_W-1:0] lane_q;

            if (l == 0) begin : g_leaf
                assign val_a  = corr_i[2*n];
                assign val_b  = corr_i[2*n+1];
                assign lane_a = sync_pkg::LANE_W'(2*n);
                assign lane_b = sync_pkg::LANE_W'(2*n+1);
            end else begin : g_inner
                assign val_a  = g_lvl[l-1].g_node[2*n].val_q;
                assign val_b  = g_lvl[l-1].g_node[2*n+1].val_q;
                assign lane_a = g_lvl[l-1].g_node[2*n].lane_q;
                assign lane_b = g_lvl[l-1].g_node[2*n+1].lane_q;
            end

            // strict compare, so a tie keeps the lower lane
            always_ff @(posedge clk_i) begin
                if (val_b > val_a) begin
                    val_q  <= val_b;
                    lane_q <= lane_b;
                end else begin
                    val_q  <= val_a;
                    lane_q <= lane_a;
                end
            end
        end
    end

    assign peak_o = '{
        value: g_lvl[sync_pkg::TREE_LAT-1].g_node[0].val_q,
        lane:  g_lvl[sync_pkg::TREE_LAT-1].g_node[0].lane_q,
        stamp: stamp_dly
    };

endmodule

// File: src/sync_pkg.sv
package sync_pkg;

    // bus geometry
    localparam int PHASES    = 16;
    localparam int SAMPLE_W  = 16;
    localparam int CORR_W    = 32;
    localparam int LANE_W    = 4;
    localparam int FCYC_W    = 8;
    localparam int ADDR_W    = 12;
    // flags that must all be high for one detection
    localparam int PD_WINDOW = 16;

    // one register per compare layer
    localparam int TREE_LAT     = 4;
    // frame cycles allowed to carry the timing peak
    localparam int SEARCH_FIRST = 4;
    localparam int SEARCH_LAST  = 28;
    // twelve symbols of 64 + 16 samples
    localparam int DATA_SAMPLES = 960;
    // sample path delay, covers search plus boundary computation
    localparam int DATA_DELAY   = 40;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } sample_t;

    // lane 0 is the earliest sample of the clock
    typedef sample_t [PHASES-1:0] lanes_t;

    // unsigned cross-correlation magnitudes, one per lane
    typedef logic [PHASES-1:0][CORR_W-1:0] corr_t;

    typedef struct packed {
        logic [CORR_W-1:0] value;
        logic [LANE_W-1:0] lane;
        logic [FCYC_W-1:0] stamp;
    } peak_t;

    // in_frame kept at bit 0, the flag position cleared by delay_line reset
    typedef struct packed {
        lanes_t            samples;
        logic [FCYC_W-1:0] fcyc;
        logic              in_frame;
    } tagged_t;

    // inclusive sample addresses of the data region
    typedef struct packed {
        logic [ADDR_W-1:0] data_start;
        logic [ADDR_W-1:0] data_end;
        logic              valid;
    } bounds_t;

endpackage

// File: tests/ofdm_sync_assert.sv
module ofdm_sync_assert (
    input logic                        clk_i,
    input logic                        rst_i,
    input logic [sync_pkg::PHASES-1:0] valid_i,
    input logic                        bounds_valid_i,
    input logic                        det_i,
    input logic                        in_frame_i,
    input logic [sync_pkg::FCYC_W-1:0] fcyc_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // mask held clear once reset has been seen for a full cycle
    a_reset_quiet: assert property (@(posedge clk_i)
        rst_i && $past(rst_i) |-> valid_i == '0)
        else $error("valid mask active during reset");

    // mask register follows the bounds by one cycle
    a_no_bounds: assert property (@(posedge clk_i) disable iff (rst_i)
        !bounds_valid_i |=> valid_i == '0)
        else $error("valid mask set without valid bounds");

    // busy strobe must not restart the counter, only count on or rearm
    a_busy_det: assert property (@(posedge clk_i) disable iff (rst_i)
        in_frame_i && det_i |=> (fcyc_i == $past(fcyc_i) + sync_pkg::FCYC_W'(1))
                             || (fcyc_i == '0))
        else $error("detection strobe restarted a running frame");

endmodule

// File: tests/ofdm_sync_tb.sv
module ofdm_sync_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS    = 4;
    // output follows input by the delay line plus the output register
    localparam int LAT       = sync_pkg::DATA_DELAY + 1;
    localparam int MAX_CYC   = 360;
    localparam int LEN_SHORT = 120;
    localparam int LEN_ONE   = 180;
    localparam int LEN_TWO   = 340;
    // every test length plus reset and slack
    localparam int RUN_CYC   = LEN_SHORT + 3 * LEN_ONE + 2 * LEN_TWO + 200;
    localparam logic [sync_pkg::CORR_W-1:0] PEAK_V = 32'h4000_0000;

    logic                        clk;
    logic                        rst;
    sync_pkg::lanes_t            samples;
    logic [sync_pkg::PHASES-1:0] flags;
    sync_pkg::corr_t             corr;
    sync_pkg::lanes_t            data_out;
    logic [sync_pkg::PHASES-1:0] valid_out;

    // per-test stimulus and expected mask, indexed by input cycle
    sync_pkg::lanes_t            stim_smp  [MAX_CYC];
    logic [sync_pkg::PHASES-1:0] stim_flg  [MAX_CYC];
    sync_pkg::corr_t             stim_corr [MAX_CYC];
    logic [sync_pkg::PHASES-1:0] exp_mask  [MAX_CYC];
    int                          gcyc;
    int                          data_errs;
    int                          mask_errs;

    tb_clock u_clock (.clk_o(clk));

    ofdm_sync dut_i (
        .clk_i    (clk),
        .rst_i    (rst),
        .samples_i(samples),
        .flags_i  (flags),
        .corr_i   (corr),
        .data_o   (data_out),
        .valid_o  (valid_out)
    );

    bind ofdm_sync ofdm_sync_assert u_assert (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .valid_i       (valid_o),
        .bounds_valid_i(bounds.valid),
        .det_i         (det),
        .in_frame_i    (in_frame),
        .fcyc_i        (fcyc)
    );

    task automatic check_data(input sync_pkg::lanes_t got, input sync_pkg::lanes_t exp,
                              input string what);
        if (got !== exp) begin
            data_errs++;
            $display("Mismatch at %0t: %s data got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input logic [sync_pkg::PHASES-1:0] got,
                              input logic [sync_pkg::PHASES-1:0] exp, input string what);
        if (got !== exp) begin
            mask_errs++;
            $display("Mismatch at %0t: %s mask got %h expected %h", $time, what, got, exp);
        end
    endtask

    // re carries cycle and lane, flags always miss one bit, small correlation
    task automatic fill_background(input int len);
        int m;
        int k;
        for (m = 0; m < len; m++) begin
            for (k = 0; k < sync_pkg::PHASES; k++) begin
                stim_smp[m][k].re = sync_pkg::SAMPLE_W'((gcyc + m) * sync_pkg::PHASES + k);
                stim_smp[m][k].im = sync_pkg::SAMPLE_W'($urandom);
                stim_corr[m][k]   = sync_pkg::CORR_W'($urandom % 1024);
            end
            stim_flg[m] = sync_pkg::PHASES'($urandom)
                        & ~(sync_pkg::PHASES'(1) << (m % sync_pkg::PHASES));
            exp_mask[m] = '0;
        end
    endtask

    task automatic place_window(input int c);
        stim_flg[c] = '1;
    endtask

    // stamp counts from the flag window cycle
    task automatic place_peak(input int c, input int stamp, input int lane,
                              input logic [sync_pkg::CORR_W-1:0] value);
        stim_corr[c + stamp][lane] = value;
    endtask

    // reference: detection, busy window, peak choice and data region
    task automatic expect_frames(input int len);
        int c;
        int s;
        int k;
        int f;
        int addr;
        int pa;
        int end_a;
        int busy_until;
        logic found;
        logic [sync_pkg::CORR_W-1:0] best_v;
        busy_until = -1;
        for (c = 0; c < len; c++) begin
            if (&stim_flg[c] && c > busy_until) begin
                found  = 1'b0;
                best_v = '0;
                pa     = 0;
                // earliest stamp, then lowest lane, wins equal values
                for (s = sync_pkg::SEARCH_FIRST; s <= sync_pkg::SEARCH_LAST; s++) begin
                    for (k = 0; k < sync_pkg::PHASES; k++) begin
                        if (!found || stim_corr[c + s][k] > best_v) begin
                            found  = 1'b1;
                            best_v = stim_corr[c + s][k];
                            pa     = s * sync_pkg::PHASES + k;
                        end
                    end
                end
                end_a = pa + sync_pkg::DATA_SAMPLES;
                for (f = 0; c + f < len; f++) begin
                    for (k = 0; k < sync_pkg::PHASES; k++) begin
                        addr = f * sync_pkg::PHASES + k;
                        if (addr > pa && addr <= end_a) begin
                            exp_mask[c + f][k] = 1'b1;
                        end
                    end
                end
                // flag windows up to here land in a busy frame
                busy_until = c + end_a / sync_pkg::PHASES + sync_pkg::DATA_DELAY;
            end
        end
    endtask

    // drive one cycle per edge, outputs read just before the next drive
    task automatic run_test(input string what, input int len);
        int r;
        expect_frames(len);
        for (r = 0; r < len; r++) begin
            @(posedge clk);
            #1;
            if (r >= LAT) begin
                check_data(data_out, stim_smp[r - LAT], what);
                check_mask(valid_out, exp_mask[r - LAT], what);
            end else begin
                // tail of the previous test, no frame left open
                check_mask(valid_out, '0, what);
            end
            samples = stim_smp[r];
            flags   = stim_flg[r];
            corr    = stim_corr[r];
        end
        gcyc += len;
    endtask

    task automatic test_missed_detection();
        fill_background(LEN_SHORT);
        // fifteen of sixteen flags, not a packet
        stim_flg[10] = ~(sync_pkg::PHASES'(1) << 8);
        place_peak(10, 20, 5, PEAK_V);
        run_test("missed detection", LEN_SHORT);
    endtask

    task automatic test_clean_frame();
        fill_background(LEN_ONE);
        place_window(4);
        place_peak(4, 20, 5, PEAK_V);
        run_test("clean frame", LEN_ONE);
    endtask

    task automatic test_last_lane();
        fill_background(LEN_ONE);
        place_window(4);
        place_peak(4, 17, 15, PEAK_V);
        run_test("last lane", LEN_ONE);
    endtask

    task automatic test_ties();
        fill_background(LEN_TWO);
        // lane tie within one cycle
        place_window(4);
        place_peak(4, 12, 3, PEAK_V);
        place_peak(4, 12, 9, PEAK_V);
        // stamp tie across cycles
        place_window(154);
        place_peak(154, 10, 7, PEAK_V);
        place_peak(154, 22, 7, PEAK_V);
        run_test("ties", LEN_TWO);
    endtask

    task automatic test_window_limit();
        fill_background(LEN_ONE);
        place_window(4);
        place_peak(4, 3, 1, PEAK_V + 32'd1000);
        place_peak(4, 30, 2, PEAK_V + 32'd1000);
        place_peak(4, 15, 8, PEAK_V);
        run_test("window limit", LEN_ONE);
    endtask

    task automatic test_back_to_back();
        fill_background(LEN_TWO);
        place_window(4);
        place_peak(4, 24, 0, PEAK_V);
        // lands in the extract phase of the first frame
        place_window(64);
        place_peak(64, 20, 2, PEAK_V + 32'd5);
        place_window(154);
        place_peak(154, 6, 11, PEAK_V);
        run_test("back to back", LEN_TWO);
    endtask

    initial begin
        #(RUN_CYC * CLK_NS);
        $display("timeout: run still going after %0d cycles", RUN_CYC);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(32'hf281));
        rst       = 1'b1;
        samples   = '0;
        flags     = '0;
        corr      = '0;
        gcyc      = 0;
        data_errs = 0;
        mask_errs = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_missed_detection();
        test_clean_frame();
        test_last_lane();
        test_ties();
        test_window_limit();
        test_back_to_back();
        $display("closing: %0d data errors, %0d mask errors", data_errs, mask_errs);
        if (data_errs + mask_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    localparam int HALF_NS = 2;

    initial clk_o = 1'b0;

    always #HALF_NS clk_o = ~clk_o;

endmodule
